// File: hw/mac_pkg.sv
////////////////////
// mac lane shared definitions
// element union, datapath widths, mode encoding
////////////////////
`default_nettype none

package mac_pkg;

    // element word: zero flag, sign, 8-bit payload
    localparam int ELEM_W = 10;
    localparam int EXP_W  = 4;
    localparam int MANT_W = 4;
    localparam int MAG_W  = 8;

    localparam int PEXP_W = 5;   // sum of two fp8 exponents
    localparam int TERM_W = 17;  // sign + 16-bit product magnitude

    localparam int N_STAGE = 4;

    // one-bit lane mode
    localparam logic MODE_FP8 = 1'b0;
    localparam logic MODE_INT = 1'b1;

    typedef struct packed {
        logic              zero;
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] mant;
    } mac_fp8_t;

    typedef struct packed {
        logic             zero;
        logic             sign;
        logic [MAG_W-1:0] mag;
    } mac_int_t;

    // same word, decoded per mode
    typedef union packed {
        mac_fp8_t fp;
        mac_int_t ival;
    } mac_elem_u;

endpackage

`default_nettype wire

// File: hw/mac_pipe_ctrl.sv
////////////////////
// mac lane pipeline control
// slot-full flags and per-stage load enables
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_pipe_ctrl (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic                        i_ready,
    output logic                        o_ready,
    output logic                        o_valid,
    output logic [mac_pkg::N_STAGE-1:0] o_stage_en
);
    import mac_pkg::*;

    logic [N_STAGE-1:0] vld;
    logic [N_STAGE-1:0] nxt_move;
    logic [N_STAGE-1:0] vld_src;

    // downstream can take a beat: output port or next stage load
    assign nxt_move = {i_ready, o_stage_en[N_STAGE-1:1]};

    // stage loads when empty or when its beat moves on
    assign o_stage_en = ~vld | nxt_move;

    assign vld_src = {vld[N_STAGE-2:0], i_valid};

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            vld <= '0;
        end else begin
            for (int k = 0; k < N_STAGE; k++) begin
                if (o_stage_en[k]) begin
                    vld[k] <= vld_src[k];  // bubble when upstream empty
                end
            end
        end
    end

    assign o_ready = o_stage_en[0];
    assign o_valid = vld[N_STAGE-1];

endmodule

`default_nettype wire

// File: hw/mac_mult_stage.sv
////////////////////
// mac lane multiply stage
// element decode, drop masking, pairwise product
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_mult_stage #(
    parameter int N_ELEM = 8
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_en,
    input  logic                                   i_int_mode,
    input  mac_pkg::mac_elem_u [N_ELEM-1:0]        i_act,
    input  mac_pkg::mac_elem_u [N_ELEM-1:0]        i_wgt,
    input  logic [N_ELEM-1:0]                      i_elem_valid,
    output logic [N_ELEM-1:0]                      o_sign,
    output logic [mac_pkg::TERM_W-2:0]             o_mag [N_ELEM],
    output logic [mac_pkg::PEXP_W-1:0]             o_exp [N_ELEM]
);
    import mac_pkg::*;

    localparam int PMAG_W = TERM_W - 1;

    logic [N_ELEM-1:0] sign_c;
    logic [PMAG_W-1:0] mag_c [N_ELEM];
    logic [PEXP_W-1:0] exp_c [N_ELEM];

    for (genvar i = 0; i < N_ELEM; i++) begin : g_elem
        logic                drop;
        logic [MANT_W:0]     fp_a;
        logic [MANT_W:0]     fp_b;
        logic [2*MANT_W+1:0] fp_prod;
        logic [2*MAG_W-1:0]  int_prod;

        // zero flag sits at the same bit in both views
        assign drop = i_act[i].fp.zero | i_wgt[i].fp.zero | ~i_elem_valid[i];

        assign fp_a     = {1'b1, i_act[i].fp.mant};  // implicit leading one
        assign fp_b     = {1'b1, i_wgt[i].fp.mant};
        assign fp_prod  = fp_a * fp_b;
        assign int_prod = i_act[i].ival.mag * i_wgt[i].ival.mag;

        always_comb begin
            if (drop) begin
                sign_c[i] = 1'b0;
                mag_c[i]  = '0;
                exp_c[i]  = '0;
            end else begin
                sign_c[i] = i_act[i].fp.sign ^ i_wgt[i].fp.sign;  // same bit in both views
                if (i_int_mode == MODE_INT) begin
                    mag_c[i] = int_prod;
                    exp_c[i] = '0;
                end else begin
                    mag_c[i] = PMAG_W'(fp_prod);
                    exp_c[i] = PEXP_W'(i_act[i].fp.exp) + PEXP_W'(i_wgt[i].fp.exp);
                end
            end
        end
    end

    ////////////////////
    // stage register
    ////////////////////
    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_sign <= '0;
            for (int i = 0; i < N_ELEM; i++) begin
                o_mag[i] <= '0;
                o_exp[i] <= '0;
            end
        end else if (i_en) begin
            o_sign <= sign_c;
            for (int i = 0; i < N_ELEM; i++) begin
                o_mag[i] <= mag_c[i];
                o_exp[i] <= exp_c[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mac_align_prep_stage.sv
////////////////////
// mac lane align prep stage
// max exponent, two's complement, shift distances
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_align_prep_stage #(
    parameter int N_ELEM = 8
) (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_en,
    input  logic [N_ELEM-1:0]                 i_sign,
    input  logic [mac_pkg::TERM_W-2:0]        i_mag [N_ELEM],
    input  logic [mac_pkg::PEXP_W-1:0]        i_exp [N_ELEM],
    output logic signed [mac_pkg::TERM_W-1:0] o_term [N_ELEM],
    output logic [mac_pkg::PEXP_W-1:0]        o_shift [N_ELEM],
    output logic [mac_pkg::PEXP_W-1:0]        o_max_exp
);
    import mac_pkg::*;

    logic [PEXP_W-1:0]        max_c;
    logic signed [TERM_W-1:0] term_c [N_ELEM];

    // dropped elements carry exponent 0
    always_comb begin
        max_c = '0;
        for (int i = 0; i < N_ELEM; i++) begin
            if (i_exp[i] > max_c) begin
                max_c = i_exp[i];
            end
        end
    end

    for (genvar i = 0; i < N_ELEM; i++) begin : g_term
        assign term_c[i] = i_sign[i] ? -$signed({1'b0, i_mag[i]}) : $signed({1'b0, i_mag[i]});
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_max_exp <= '0;
            for (int i = 0; i < N_ELEM; i++) begin
                o_term[i]  <= '0;
                o_shift[i] <= '0;
            end
        end else if (i_en) begin
            o_max_exp <= max_c;
            for (int i = 0; i < N_ELEM; i++) begin
                o_term[i]  <= term_c[i];
                o_shift[i] <= max_c - i_exp[i];  // never negative
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mac_align_shift_stage.sv
////////////////////
// mac lane align shift stage
// arithmetic right shift of each term
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_align_shift_stage #(
    parameter int N_ELEM = 8
) (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_en,
    input  logic signed [mac_pkg::TERM_W-1:0] i_term [N_ELEM],
    input  logic [mac_pkg::PEXP_W-1:0]        i_shift [N_ELEM],
    input  logic [mac_pkg::PEXP_W-1:0]        i_max_exp,
    output logic signed [mac_pkg::TERM_W-1:0] o_term [N_ELEM],
    output logic [mac_pkg::PEXP_W-1:0]        o_max_exp
);
    import mac_pkg::*;

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_max_exp <= '0;
            for (int i = 0; i < N_ELEM; i++) begin
                o_term[i] <= '0;
            end
        end else if (i_en) begin
            o_max_exp <= i_max_exp;
            // floor shift, large distances settle at 0 or -1
            for (int i = 0; i < N_ELEM; i++) begin
                o_term[i] <= i_term[i] >>> i_shift[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mac_reduce_stage.sv
////////////////////
// mac lane reduce stage
// balanced adder tree and output register
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_reduce_stage #(
    parameter int N_ELEM = 8
) (
    input  logic                                               i_clk,
    input  logic                                               i_reset,
    input  logic                                               i_en,
    input  logic signed [mac_pkg::TERM_W-1:0]                  i_term [N_ELEM],
    input  logic [mac_pkg::PEXP_W-1:0]                         i_max_exp,
    output logic signed [mac_pkg::TERM_W+$clog2(N_ELEM)-1:0]   o_sum,
    output logic [mac_pkg::PEXP_W-1:0]                         o_max_exp
);
    import mac_pkg::*;

    localparam int SUM_W = TERM_W + $clog2(N_ELEM);

    // heap layout, root at 0, leaves at N_ELEM-1 and up
    logic signed [SUM_W-1:0] node [2*N_ELEM-1];

    for (genvar i = 0; i < N_ELEM; i++) begin : g_leaf
        assign node[N_ELEM-1+i] = i_term[i];  // sign extended
    end

    for (genvar k = 0; k < N_ELEM-1; k++) begin : g_add
        assign node[k] = node[2*k+1] + node[2*k+2];
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            o_sum     <= '0;
            o_max_exp <= '0;
        end else if (i_en) begin
            o_sum     <= node[0];
            o_max_exp <= i_max_exp;
        end
    end

endmodule

`default_nettype wire

// File: hw/mac_lane_top.sv
////////////////////
// mac lane top
// four-stage fp8/int dot-product lane with valid/ready
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_lane_top #(
    parameter int N_ELEM = 8
) (
    input  logic                                             i_clk,
    input  logic                                             i_reset,
    input  logic                                             i_valid,
    output logic                                             o_ready,
    input  mac_pkg::mac_elem_u [N_ELEM-1:0]                  i_act,
    input  mac_pkg::mac_elem_u [N_ELEM-1:0]                  i_wgt,
    input  logic [N_ELEM-1:0]                                i_elem_valid,
    input  logic                                             i_int_mode,
    output logic                                             o_valid,
    input  logic                                             i_ready,
    output logic signed [mac_pkg::TERM_W+$clog2(N_ELEM)-1:0] o_sum,
    output logic [mac_pkg::PEXP_W-1:0]                       o_max_exp
);
    import mac_pkg::*;

    logic [N_STAGE-1:0]       stage_en;

    logic [N_ELEM-1:0]        term_sign;
    logic [TERM_W-2:0]        terms_mag [N_ELEM];
    logic [PEXP_W-1:0]        term_exp [N_ELEM];

    logic signed [TERM_W-1:0] prep_term [N_ELEM];
    logic [PEXP_W-1:0]        prep_shift [N_ELEM];
    logic [PEXP_W-1:0]        prep_max_exp;

    logic signed [TERM_W-1:0] align_term [N_ELEM];
    logic [PEXP_W-1:0]        align_max_exp;

    mac_pipe_ctrl u_ctrl (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_ready    (i_ready),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_stage_en (stage_en)
    );

    mac_mult_stage #(.N_ELEM(N_ELEM)) u_mult (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_en         (stage_en[0]),
        .i_int_mode   (i_int_mode),
        .i_act        (i_act),
        .i_wgt        (i_wgt),
        .i_elem_valid (i_elem_valid),
        .o_sign       (term_sign),
        .o_mag        (terms_mag),
        .o_exp        (term_exp)
    );

    mac_align_prep_stage #(.N_ELEM(N_ELEM)) u_prep (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_en      (stage_en[1]),
        .i_sign    (term_sign),
        .i_mag     (terms_mag),
        .i_exp     (term_exp),
        .o_term    (prep_term),
        .o_shift   (prep_shift),
        .o_max_exp (prep_max_exp)
    );

    mac_align_shift_stage #(.N_ELEM(N_ELEM)) u_shift (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_en      (stage_en[2]),
        .i_term    (prep_term),
        .i_shift   (prep_shift),
        .i_max_exp (prep_max_exp),
        .o_term    (align_term),
        .o_max_exp (align_max_exp)
    );

    mac_reduce_stage #(.N_ELEM(N_ELEM)) u_reduce (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_en      (stage_en[3]),
        .i_term    (align_term),
        .i_max_exp (align_max_exp),
        .o_sum     (o_sum),
        .o_max_exp (o_max_exp)
    );

endmodule

`default_nettype wire

// File: dv/mac_lane_clkgen.sv
////////////////////
// mac lane testbench clock and reset
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_lane_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // active low, released on a falling edge
    initial begin
        o_reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/mac_lane_tb.sv
////////////////////
// mac lane testbench
// random fp8/int beats, scoreboard queue, handshake assertions
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mac_lane_tb;
    import mac_pkg::*;

    localparam int N_ELEM     = 8;
    localparam int SUM_W      = TERM_W + $clog2(N_ELEM);
    localparam int N_BEATS    = 300;  // 60 + 60 + 60 + 120
    localparam int MAX_CYCLES = N_BEATS * 6 + 200;
    localparam int K_FP8      = 0;
    localparam int K_ALT      = 1;
    localparam int K_DROP     = 2;
    localparam int K_BP       = 3;

    logic                    i_clk;
    logic                    i_reset;
    logic                    i_valid;
    logic                    o_ready;
    mac_elem_u [N_ELEM-1:0]  i_act;
    mac_elem_u [N_ELEM-1:0]  i_wgt;
    logic [N_ELEM-1:0]       i_elem_valid;
    logic                    i_int_mode;
    logic                    o_valid;
    logic                    i_ready;
    logic signed [SUM_W-1:0] o_sum;
    logic [PEXP_W-1:0]       o_max_exp;

    logic signed [SUM_W-1:0] exp_sum_q [$];
    logic [PEXP_W-1:0]       exp_max_q [$];
    logic signed [SUM_W-1:0] head_sum = '0;
    logic [PEXP_W-1:0]       head_max = '0;
    logic                    head_vld = 1'b0;
    logic [3:0]              acc_hist = '0;  // accept history, bit 3 is 4 edges back
    logic                    in_taken = 1'b0;
    logic                    steady;         // i_ready held high
    logic                    bp_mode;
    int                      inflight = 0;
    int                      beats_in = 0;
    int                      beats_out = 0;
    int                      err_cnt = 0;
    int                      cycle_cnt = 0;

    mac_lane_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clkgen (
        .o_clk   (i_clk),
        .o_reset (i_reset)
    );

    mac_lane_top #(.N_ELEM(N_ELEM)) DUT (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_act        (i_act),
        .i_wgt        (i_wgt),
        .i_elem_valid (i_elem_valid),
        .i_int_mode   (i_int_mode),
        .o_valid      (o_valid),
        .i_ready      (i_ready),
        .o_sum        (o_sum),
        .o_max_exp    (o_max_exp)
    );

    ////////////////////
    // reference model
    ////////////////////
    function automatic longint floor_shift(input longint t, input int d);
        longint p;
        p = longint'(1) << d;
        if (t >= 0) begin
            return t / p;
        end
        return -((-t + p - 1) / p);  // round toward minus infinity
    endfunction

    task automatic push_expected();
        logic [ELEM_W-1:0] a;
        logic [ELEM_W-1:0] w;
        longint            mag [N_ELEM];
        int                ex [N_ELEM];
        bit                neg [N_ELEM];
        longint            sum;
        int                mx;
        sum = 0;
        mx  = 0;
        for (int i = 0; i < N_ELEM; i++) begin
            a = i_act[i];
            w = i_wgt[i];
            neg[i] = a[8] ^ w[8];
            if (a[9] || w[9] || !i_elem_valid[i]) begin
                mag[i] = 0;
                ex[i]  = 0;
                neg[i] = 1'b0;
            end else if (i_int_mode == MODE_INT) begin
                mag[i] = longint'(a[7:0]) * longint'(w[7:0]);
                ex[i]  = 0;
            end else begin
                mag[i] = longint'(16 + a[3:0]) * longint'(16 + w[3:0]);
                ex[i]  = a[7:4] + w[7:4];
            end
            if (ex[i] > mx) begin
                mx = ex[i];
            end
        end
        for (int i = 0; i < N_ELEM; i++) begin
            sum += floor_shift(neg[i] ? -mag[i] : mag[i], mx - ex[i]);
        end
        exp_sum_q.push_back(SUM_W'(sum));
        exp_max_q.push_back(PEXP_W'(mx));
    endtask

    // transfers seen at each rising edge
    always @(posedge i_clk) begin
        in_taken = i_reset && i_valid && o_ready;
        if (i_reset && o_valid && i_ready && exp_sum_q.size() > 0) begin
            void'(exp_sum_q.pop_front());
            void'(exp_max_q.pop_front());
            beats_out++;
        end
        if (in_taken) begin
            push_expected();
            beats_in++;
        end
        acc_hist <= {acc_hist[2:0], in_taken};
        inflight <= exp_sum_q.size();
        head_vld <= exp_sum_q.size() > 0;
        if (exp_sum_q.size() > 0) begin
            head_sum <= exp_sum_q[0];
            head_max <= exp_max_q[0];
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    always @(negedge i_clk) begin
        i_ready = bp_mode ? 1'($urandom_range(1)) : 1'b1;
    end

    ////////////////////
    // checks
    ////////////////////
    a_reset_idle: assert property (@(posedge i_clk) !i_reset |-> !o_valid && o_ready)
        else begin
            err_cnt++;
            $display("o_valid high or o_ready low while reset is held");
        end

    a_reset_exit: assert property (@(posedge i_clk) $rose(i_reset) |-> !o_valid && o_ready)
        else begin
            err_cnt++;
            $display("o_valid high or o_ready low right after reset");
        end

    a_latency: assert property (@(posedge i_clk) disable iff (!i_reset)
        steady |-> o_valid == acc_hist[3])
        else begin
            err_cnt++;
            $display("o_valid not exactly 4 cycles after an accepted beat");
        end

    a_pending: assert property (@(posedge i_clk) disable iff (!i_reset)
        o_valid && i_ready |-> head_vld)
        else begin
            err_cnt++;
            $display("output beat delivered with no beat pending");
        end

    a_sum: assert property (@(posedge i_clk) disable iff (!i_reset)
        o_valid && i_ready && head_vld |-> o_sum == head_sum)
        else begin
            err_cnt++;
            $display("Mismatch o_sum: got %h expected %h", $sampled(o_sum), $sampled(head_sum));
        end

    a_max: assert property (@(posedge i_clk) disable iff (!i_reset)
        o_valid && i_ready && head_vld |-> o_max_exp == head_max)
        else begin
            err_cnt++;
            $display("Mismatch o_max_exp: got %h expected %h",
                     $sampled(o_max_exp), $sampled(head_max));
        end

    a_hold: assert property (@(posedge i_clk) disable iff (!i_reset)
        o_valid && !i_ready |=> o_valid && $stable(o_sum) && $stable(o_max_exp))
        else begin
            err_cnt++;
            $display("output beat changed or dropped while held by back-pressure");
        end

    a_ready: assert property (@(posedge i_clk) disable iff (!i_reset)
        !o_ready |-> inflight == 4)
        else begin
            err_cnt++;
            $display("o_ready low while %0d beats are held", $sampled(inflight));
        end

    ////////////////////
    // stimulus
    ////////////////////
    function automatic logic [ELEM_W-1:0] rand_elem(input bit with_zero);
        logic zero;
        zero = with_zero && ($urandom_range(3) == 0);
        return {zero, 1'($urandom_range(1)), 8'($urandom)};
    endfunction

    task automatic run_beats(input int kind, input int n);
        for (int b = 0; b < n; b++) begin
            if (kind == K_BP && $urandom_range(3) == 0) begin
                i_valid = 1'b0;  // idle gap
                @(negedge i_clk);
            end
            for (int i = 0; i < N_ELEM; i++) begin
                i_act[i] = rand_elem(kind >= K_DROP);
                i_wgt[i] = rand_elem(kind >= K_DROP);
            end
            i_elem_valid = (kind >= K_DROP) ? N_ELEM'($urandom) : '1;
            case (kind)
                K_FP8:   i_int_mode = MODE_FP8;
                K_ALT:   i_int_mode = b[0] ? MODE_FP8 : MODE_INT;
                default: i_int_mode = 1'($urandom_range(1));
            endcase
            i_valid = 1'b1;
            do begin
                @(negedge i_clk);
            end while (!in_taken);
        end
        i_valid = 1'b0;
        bp_mode = 1'b0;
        while (inflight != 0) begin
            @(negedge i_clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-12s done: %0d beats in total, %0d errors",
                 name, beats_in, err_cnt - errs_before);
    endtask

    initial begin
        int errs;
        void'($urandom(32'hbf0a));
        i_valid      = 1'b0;
        i_ready      = 1'b1;
        i_act        = '0;
        i_wgt        = '0;
        i_elem_valid = '0;
        i_int_mode   = MODE_FP8;
        steady       = 1'b1;
        bp_mode      = 1'b0;
        errs         = 0;
        wait (i_reset === 1'b1);
        repeat (2) @(negedge i_clk);
        report_test("reset", errs);

        errs = err_cnt;
        run_beats(K_FP8, 60);
        report_test("fp8_align", errs);

        errs = err_cnt;
        run_beats(K_ALT, 60);
        report_test("int_mode", errs);

        errs = err_cnt;
        run_beats(K_DROP, 60);
        report_test("dropped", errs);

        errs    = err_cnt;
        steady  = 1'b0;
        bp_mode = 1'b1;
        run_beats(K_BP, 120);
        if (beats_in != beats_out) begin
            err_cnt++;
            $display("%0d beats accepted but %0d delivered", beats_in, beats_out);
        end
        report_test("backpressure", errs);

        $display("summary: 5 tests, %0d beats in, %0d beats out, %0d errors",
                 beats_in, beats_out, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mac_lane_top.f
hw/mac_pkg.sv
hw/mac_pipe_ctrl.sv
hw/mac_mult_stage.sv
hw/mac_align_prep_stage.sv
hw/mac_align_shift_stage.sv
hw/mac_reduce_stage.sv
hw/mac_lane_top.sv
dv/mac_lane_clkgen.sv
dv/mac_lane_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mac lane testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f mac_lane_top.f \
    --top-module mac_lane_tb -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vmac_lane_tb > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"

[ -f sim.log ] && cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log 2>/dev/null \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
